/* include/rr_config.svh */
`ifndef RR_CONFIG_SVH
`define RR_CONFIG_SVH

// datapath width
`define RR_XLEN 32

// register file geometry
`define RR_AW   5
`define RR_NREG 32

// exception code carried with the bundle
`define RR_EXCW 7

// decoded immediate
`define RR_IMMW 32

`endif

/* src/rr_pkg.sv */
`default_nettype none

`include "rr_config.svh"

package rr_pkg;

    // one decoded instruction
    typedef struct packed {
        logic [`RR_XLEN-1:0] pc;
        logic [`RR_XLEN-1:0] inst;
        logic [`RR_IMMW-1:0] imm;
        logic [`RR_AW-1:0]   rj;
        logic [`RR_AW-1:0]   rk;
        logic [`RR_AW-1:0]   rd;
        logic                is_alu;
        logic                is_load;
        logic                is_syscall;
        logic                is_break;
        logic                is_priv;
    } rr_slot_t;

    // dual-issue bundle from decode
    typedef struct packed {
        rr_slot_t            slot0;
        rr_slot_t            slot1;
        logic [`RR_XLEN-1:0] pc_next;
        logic                pc_taken;
        logic                branch_flag;
        logic                excp_flag;
        logic [`RR_EXCW-1:0] exception;
        logic [`RR_XLEN-1:0] badv;
    } rr_bundle_t;

    typedef struct packed {
        logic [`RR_XLEN-1:0] rj0;
        logic [`RR_XLEN-1:0] rk0;
        logic [`RR_XLEN-1:0] rj1;
        logic [`RR_XLEN-1:0] rk1;
    } rr_operands_t;

    typedef struct packed {
        logic                we;
        logic [`RR_AW-1:0]   addr;
        logic [`RR_XLEN-1:0] data;
    } rr_wb_port_t;

    // late forward lane from execute or memory
    typedef struct packed {
        logic                flag;
        logic [`RR_XLEN-1:0] data;
    } rr_fwd_t;

endpackage

`default_nettype wire

/* src/reg_file.sv */
`default_nettype none

`include "rr_config.svh"

module reg_file (
    input  logic                clk,
    input  logic                aresetn,
    input  rr_pkg::rr_wb_port_t wr0,
    input  rr_pkg::rr_wb_port_t wr1,
    input  rr_pkg::rr_wb_port_t wr2,
    input  logic [`RR_AW-1:0]   raddr_j0,
    input  logic [`RR_AW-1:0]   raddr_k0,
    input  logic [`RR_AW-1:0]   raddr_j1,
    input  logic [`RR_AW-1:0]   raddr_k1,
    output logic [`RR_XLEN-1:0] rdata_j0,
    output logic [`RR_XLEN-1:0] rdata_k0,
    output logic [`RR_XLEN-1:0] rdata_j1,
    output logic [`RR_XLEN-1:0] rdata_k1
);

    logic [`RR_XLEN-1:0] regs [`RR_NREG];

    // write-first read, later ports override earlier ones
    function automatic logic [`RR_XLEN-1:0] read_port(
        input logic [`RR_AW-1:0]   addr,
        input logic [`RR_XLEN-1:0] stored,
        input rr_pkg::rr_wb_port_t p0,
        input rr_pkg::rr_wb_port_t p1,
        input rr_pkg::rr_wb_port_t p2
    );
        logic [`RR_XLEN-1:0] val;
        val = stored;
        if (p0.we && p0.addr == addr) begin
            val = p0.data;
        end
        if (p1.we && p1.addr == addr) begin
            val = p1.data;
        end
        if (p2.we && p2.addr == addr) begin
            val = p2.data;
        end
        // r0 is hardwired
        if (addr == '0) begin
            val = '0;
        end
        return val;
    endfunction

    // port 2 issues its write last so it wins on a shared address
    always_ff @(posedge clk or negedge aresetn) begin
        if (!aresetn) begin
            for (int i = 0; i < `RR_NREG; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (wr0.we && wr0.addr != '0) begin
                regs[wr0.addr] <= wr0.data;
            end
            if (wr1.we && wr1.addr != '0) begin
                regs[wr1.addr] <= wr1.data;
            end
            if (wr2.we && wr2.addr != '0) begin
                regs[wr2.addr] <= wr2.data;
            end
        end
    end

    always_comb begin
        rdata_j0 = read_port(raddr_j0, regs[raddr_j0], wr0, wr1, wr2);
        rdata_k0 = read_port(raddr_k0, regs[raddr_k0], wr0, wr1, wr2);
        rdata_j1 = read_port(raddr_j1, regs[raddr_j1], wr0, wr1, wr2);
        rdata_k1 = read_port(raddr_k1, regs[raddr_k1], wr0, wr1, wr2);
    end

    // r0 reads zero on every port, also under a same-cycle write to it
    a_r0_zero : assert property (@(posedge clk) disable iff (!aresetn)
        (raddr_j0 != '0 || rdata_j0 == '0) && (raddr_k0 != '0 || rdata_k0 == '0) &&
        (raddr_j1 != '0 || rdata_j1 == '0) && (raddr_k1 != '0 || rdata_k1 == '0))
        else $error("register 0 does not read zero");

endmodule

`default_nettype wire

/* src/rr_hazard_ctrl.sv */
`default_nettype none

`include "rr_config.svh"

module rr_hazard_ctrl (
    input  logic              clk,
    input  logic              aresetn,
    input  logic [`RR_AW-1:0] src_j0,
    input  logic [`RR_AW-1:0] src_k0,
    input  logic [`RR_AW-1:0] src_j1,
    input  logic [`RR_AW-1:0] src_k1,
    input  logic [`RR_AW-1:0] ex_rd0,
    input  logic              ex_is_load0,
    input  logic              reg_readygo,
    input  logic              ex_allowin,
    input  logic              forward_stall,
    input  logic              stall_d,
    input  logic              flush,
    input  logic              flush_priv,
    output logic              reg_allowin,
    output logic              ex_readygo,
    output logic              load_stage,
    output logic              clear_stage,
    output logic              load_stall
);

    logic [`RR_AW-1:0] ex_load_rd;
    logic [`RR_AW-1:0] shadow_rd;
    logic              consume;
    logic              transfer;

    // nonzero rd matching any of the four decode sources
    function automatic logic src_hit(
        input logic [`RR_AW-1:0] rd,
        input logic [`RR_AW-1:0] j0,
        input logic [`RR_AW-1:0] k0,
        input logic [`RR_AW-1:0] j1,
        input logic [`RR_AW-1:0] k1
    );
        return (rd != '0) && (rd == j0 || rd == k0 || rd == j1 || rd == k1);
    endfunction

    assign ex_load_rd = ex_is_load0 ? ex_rd0 : '0;

    // load that left for memory last step, data not back yet
    always_ff @(posedge clk or negedge aresetn) begin
        if (!aresetn) begin
            shadow_rd <= '0;
        end else if (consume) begin
            shadow_rd <= ex_load_rd;
        end
    end

    assign load_stall = src_hit(ex_load_rd, src_j0, src_k0, src_j1, src_k1)
                      | src_hit(shadow_rd, src_j0, src_k0, src_j1, src_k1);

    assign ex_readygo  = ~forward_stall;
    assign reg_allowin = ex_allowin & ~forward_stall & ~load_stall;

    assign consume  = ex_allowin & ex_readygo;
    assign transfer = reg_readygo & reg_allowin & ex_allowin;

    // a consume with nothing behind it leaves a bubble
    assign clear_stage = flush_priv | (flush & ~stall_d) | (consume & ~transfer);
    assign load_stage  = transfer & ~clear_stage;

    a_allowin_needs_ex : assert property (@(posedge clk) disable iff (!aresetn)
        reg_allowin |-> ex_allowin)
        else $error("reg_allowin high while execute blocks");

    a_clear_load_excl : assert property (@(posedge clk) disable iff (!aresetn)
        !(clear_stage && load_stage))
        else $error("stage cleared and loaded together");

endmodule

`default_nettype wire

/* src/rr_stage_reg.sv */
`default_nettype none

module rr_stage_reg (
    input  logic                 clk,
    input  logic                 aresetn,
    input  logic                 load_stage,
    input  logic                 clear_stage,
    input  logic                 stall_d,
    input  rr_pkg::rr_bundle_t   in_bundle,
    input  rr_pkg::rr_operands_t in_operands,
    input  rr_pkg::rr_fwd_t      fwd_j0,
    input  rr_pkg::rr_fwd_t      fwd_k0,
    input  rr_pkg::rr_fwd_t      fwd_j1,
    input  rr_pkg::rr_fwd_t      fwd_k1,
    output rr_pkg::rr_bundle_t   ex_bundle,
    output rr_pkg::rr_operands_t ex_operands
);

    // lane order j0, k0, j1, k1
    logic [3:0] fwd_flag;
    logic [3:0] fwd_sticky;
    logic [3:0] fwd_take;

    assign fwd_flag = {fwd_k1.flag, fwd_j1.flag, fwd_k0.flag, fwd_j0.flag};

    // remembers a forward seen at any point of the current downstream stall
    always_ff @(posedge clk or negedge aresetn) begin
        if (!aresetn) begin
            fwd_sticky <= '0;
        end else if (!stall_d) begin
            fwd_sticky <= '0;
        end else begin
            fwd_sticky <= fwd_sticky | fwd_flag;
        end
    end

    assign fwd_take = {4{stall_d}} & (fwd_sticky | fwd_flag);

    always_ff @(posedge clk or negedge aresetn) begin
        if (!aresetn) begin
            ex_bundle <= '0;
        end else if (clear_stage) begin
            ex_bundle <= '0;
        end else if (load_stage) begin
            ex_bundle <= in_bundle;
        end
    end

    // held operands can still pick up late results while stalled
    always_ff @(posedge clk or negedge aresetn) begin
        if (!aresetn) begin
            ex_operands <= '0;
        end else if (clear_stage) begin
            ex_operands <= '0;
        end else if (load_stage) begin
            ex_operands <= in_operands;
        end else begin
            if (fwd_take[0]) begin
                ex_operands.rj0 <= fwd_j0.data;
            end
            if (fwd_take[1]) begin
                ex_operands.rk0 <= fwd_k0.data;
            end
            if (fwd_take[2]) begin
                ex_operands.rj1 <= fwd_j1.data;
            end
            if (fwd_take[3]) begin
                ex_operands.rk1 <= fwd_k1.data;
            end
        end
    end

    // a bubble must not look like a live instruction to execute
    a_clear_zeroes : assert property (@(posedge clk) disable iff (!aresetn)
        clear_stage |=> !ex_bundle.slot0.is_load && !ex_bundle.slot0.is_alu &&
        !ex_bundle.slot1.is_alu && !ex_bundle.excp_flag && !ex_bundle.branch_flag &&
        ex_bundle.slot0.rd == '0 && ex_operands == '0)
        else $error("stage register not empty after clear");

endmodule

`default_nettype wire

/* src/rr_stage_top.sv */
`default_nettype none

module rr_stage_top (
    input  logic                 clk,
    input  logic                 aresetn,
    input  rr_pkg::rr_bundle_t   reg_bundle,
    input  logic                 reg_readygo,
    input  rr_pkg::rr_wb_port_t  wb0,
    input  rr_pkg::rr_wb_port_t  wb1,
    input  rr_pkg::rr_wb_port_t  wb2,
    input  rr_pkg::rr_fwd_t      fwd_j0,
    input  rr_pkg::rr_fwd_t      fwd_k0,
    input  rr_pkg::rr_fwd_t      fwd_j1,
    input  rr_pkg::rr_fwd_t      fwd_k1,
    input  logic                 ex_allowin,
    input  logic                 forward_stall,
    input  logic                 stall_d,
    input  logic                 flush,
    input  logic                 flush_priv,
    output logic                 reg_allowin,
    output logic                 ex_readygo,
    output rr_pkg::rr_bundle_t   ex_bundle,
    output rr_pkg::rr_operands_t ex_operands
);

    rr_pkg::rr_operands_t rd_ops;
    logic                 load_stage;
    logic                 clear_stage;

    reg_file reg_file_inst (
        .clk      (clk),
        .aresetn  (aresetn),
        .wr0      (wb0),
        .wr1      (wb1),
        .wr2      (wb2),
        .raddr_j0 (reg_bundle.slot0.rj),
        .raddr_k0 (reg_bundle.slot0.rk),
        .raddr_j1 (reg_bundle.slot1.rj),
        .raddr_k1 (reg_bundle.slot1.rk),
        .rdata_j0 (rd_ops.rj0),
        .rdata_k0 (rd_ops.rk0),
        .rdata_j1 (rd_ops.rj1),
        .rdata_k1 (rd_ops.rk1)
    );

    // load_stall also feeds reg_allowin inside the block
    rr_hazard_ctrl rr_hazard_ctrl_inst (
        .clk           (clk),
        .aresetn       (aresetn),
        .src_j0        (reg_bundle.slot0.rj),
        .src_k0        (reg_bundle.slot0.rk),
        .src_j1        (reg_bundle.slot1.rj),
        .src_k1        (reg_bundle.slot1.rk),
        .ex_rd0        (ex_bundle.slot0.rd),
        .ex_is_load0   (ex_bundle.slot0.is_load),
        .reg_readygo   (reg_readygo),
        .ex_allowin    (ex_allowin),
        .forward_stall (forward_stall),
        .stall_d       (stall_d),
        .flush         (flush),
        .flush_priv    (flush_priv),
        .reg_allowin   (reg_allowin),
        .ex_readygo    (ex_readygo),
        .load_stage    (load_stage),
        .clear_stage   (clear_stage),
        .load_stall    ()
    );

    rr_stage_reg rr_stage_reg_inst (
        .clk         (clk),
        .aresetn     (aresetn),
        .load_stage  (load_stage),
        .clear_stage (clear_stage),
        .stall_d     (stall_d),
        .in_bundle   (reg_bundle),
        .in_operands (rd_ops),
        .fwd_j0      (fwd_j0),
        .fwd_k0      (fwd_k0),
        .fwd_j1      (fwd_j1),
        .fwd_k1      (fwd_k1),
        .ex_bundle   (ex_bundle),
        .ex_operands (ex_operands)
    );

endmodule

`default_nettype wire

/* bench/rr_stage_tb.sv */
`default_nettype none

`include "rr_config.svh"

module rr_stage_tb;

    timeunit 1ns;
    timeprecision 100ps;

    logic                 clk;
    logic                 aresetn;
    rr_pkg::rr_bundle_t   reg_bundle;
    logic                 reg_readygo;
    rr_pkg::rr_wb_port_t  wb0;
    rr_pkg::rr_wb_port_t  wb1;
    rr_pkg::rr_wb_port_t  wb2;
    rr_pkg::rr_fwd_t      fwd_j0;
    rr_pkg::rr_fwd_t      fwd_k0;
    rr_pkg::rr_fwd_t      fwd_j1;
    rr_pkg::rr_fwd_t      fwd_k1;
    logic                 ex_allowin;
    logic                 forward_stall;
    logic                 stall_d;
    logic                 flush;
    logic                 flush_priv;
    logic                 reg_allowin;
    logic                 ex_readygo;
    rr_pkg::rr_bundle_t   ex_bundle;
    rr_pkg::rr_operands_t ex_operands;

    logic [`RR_XLEN-1:0]       ref_regs [`RR_NREG];
    logic [`RR_AW-1:0]         shadow_rd;
    logic [3:0]                sticky_seen;
    logic [3:0]                flag_now;
    logic [3:0][`RR_XLEN-1:0]  lane_data;
    logic [3:0][`RR_XLEN-1:0]  lane_q;
    logic [3:0][`RR_XLEN-1:0]  held_op;
    rr_pkg::rr_bundle_t        exp_bundle;
    rr_pkg::rr_operands_t      exp_ops;
    logic                      exp_stall;
    logic                      exp_allowin;
    logic                      clear_now;
    logic                      bubble_now;
    logic                      hold_now;
    logic                      transfer_now;

    rr_stage_top rr_stage_top_inst (
        .clk           (clk),
        .aresetn       (aresetn),
        .reg_bundle    (reg_bundle),
        .reg_readygo   (reg_readygo),
        .wb0           (wb0),
        .wb1           (wb1),
        .wb2           (wb2),
        .fwd_j0        (fwd_j0),
        .fwd_k0        (fwd_k0),
        .fwd_j1        (fwd_j1),
        .fwd_k1        (fwd_k1),
        .ex_allowin    (ex_allowin),
        .forward_stall (forward_stall),
        .stall_d       (stall_d),
        .flush         (flush),
        .flush_priv    (flush_priv),
        .reg_allowin   (reg_allowin),
        .ex_readygo    (ex_readygo),
        .ex_bundle     (ex_bundle),
        .ex_operands   (ex_operands)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #50 clk = ~clk;
        end
    end

    task automatic report_mismatch(input string msg);
        $display("Mismatch at %0t: %s", $time, msg);
        $display("CHECKS FAILED");
        $fatal(1);
    endtask

    // value a source should see, same-cycle writes included
    function automatic logic [`RR_XLEN-1:0] model_read(input logic [`RR_AW-1:0] addr);
        logic [`RR_XLEN-1:0] v;
        v = ref_regs[addr];
        if (wb0.we && wb0.addr == addr) begin
            v = wb0.data;
        end
        if (wb1.we && wb1.addr == addr) begin
            v = wb1.data;
        end
        if (wb2.we && wb2.addr == addr) begin
            v = wb2.data;
        end
        if (addr == '0) begin
            v = '0;
        end
        return v;
    endfunction

    function automatic logic src_match(input logic [`RR_AW-1:0] rd,
                                       input rr_pkg::rr_bundle_t b);
        return rd != '0 && (rd == b.slot0.rj || rd == b.slot0.rk ||
                            rd == b.slot1.rj || rd == b.slot1.rk);
    endfunction

    // reference register array, port 2 has the last word
    always_ff @(posedge clk or negedge aresetn) begin
        if (!aresetn) begin
            for (int i = 0; i < `RR_NREG; i++) begin
                ref_regs[i] <= '0;
            end
        end else begin
            if (wb0.we && wb0.addr != '0) begin
                ref_regs[wb0.addr] <= wb0.data;
            end
            if (wb1.we && wb1.addr != '0) begin
                ref_regs[wb1.addr] <= wb1.data;
            end
            if (wb2.we && wb2.addr != '0) begin
                ref_regs[wb2.addr] <= wb2.data;
            end
        end
    end

    // expected contents, shadow load rd and sticky lanes
    always_ff @(posedge clk or negedge aresetn) begin
        if (!aresetn) begin
            exp_bundle  <= '0;
            exp_ops     <= '0;
            lane_q      <= '0;
            shadow_rd   <= '0;
            sticky_seen <= '0;
        end else begin
            exp_bundle  <= reg_bundle;
            exp_ops.rj0 <= model_read(reg_bundle.slot0.rj);
            exp_ops.rk0 <= model_read(reg_bundle.slot0.rk);
            exp_ops.rj1 <= model_read(reg_bundle.slot1.rj);
            exp_ops.rk1 <= model_read(reg_bundle.slot1.rk);
            lane_q      <= lane_data;
            if (ex_allowin && !forward_stall) begin
                shadow_rd <= ex_bundle.slot0.is_load ? ex_bundle.slot0.rd : '0;
            end
            sticky_seen <= stall_d ? (sticky_seen | flag_now) : 4'b0000;
        end
    end

    assign flag_now  = {fwd_k1.flag, fwd_j1.flag, fwd_k0.flag, fwd_j0.flag};
    assign lane_data = {fwd_k1.data, fwd_j1.data, fwd_k0.data, fwd_j0.data};
    assign held_op   = {ex_operands.rk1, ex_operands.rj1, ex_operands.rk0, ex_operands.rj0};

    assign exp_stall = (ex_bundle.slot0.is_load && src_match(ex_bundle.slot0.rd, reg_bundle))
                     || src_match(shadow_rd, reg_bundle);
    assign exp_allowin  = ex_allowin && !forward_stall && !exp_stall;
    assign clear_now    = flush_priv || (flush && !stall_d);
    assign bubble_now   = ex_allowin && !forward_stall && !reg_readygo;
    assign hold_now     = !ex_allowin && !clear_now;
    assign transfer_now = reg_readygo && reg_allowin && ex_allowin && !clear_now;

    a_readygo : assert property (@(posedge clk) disable iff (!aresetn)
        ex_readygo == !forward_stall)
        else report_mismatch("ex_readygo differs from not forward_stall");

    a_allowin : assert property (@(posedge clk) disable iff (!aresetn)
        reg_allowin == exp_allowin)
        else report_mismatch("reg_allowin wrong for load-use or back-pressure");

    a_transfer : assert property (@(posedge clk) disable iff (!aresetn)
        transfer_now |=> ex_bundle == exp_bundle && ex_operands == exp_ops)
        else report_mismatch("held bundle or operands differ from reference");

    a_hold_bundle : assert property (@(posedge clk) disable iff (!aresetn)
        hold_now |=> $stable(ex_bundle))
        else report_mismatch("ex_bundle changed while execute blocked");

    a_hold_ops : assert property (@(posedge clk) disable iff (!aresetn)
        hold_now && !stall_d |=> $stable(ex_operands))
        else report_mismatch("ex_operands changed while execute blocked");

    a_clear : assert property (@(posedge clk) disable iff (!aresetn)
        clear_now || bubble_now |=> ex_bundle == '0 && ex_operands == '0)
        else report_mismatch("stage register not zero after flush or bubble");

    for (genvar i = 0; i < 4; i++) begin : g_lane
        a_sticky : assert property (@(posedge clk) disable iff (!aresetn)
            hold_now && stall_d && (sticky_seen[i] || flag_now[i])
            |=> held_op[i] == lane_q[i])
            else report_mismatch("held operand did not take forward data");
    end

    task automatic step_cycle();
        @(posedge clk);
        #5;
    endtask

    function automatic rr_pkg::rr_slot_t random_slot();
        rr_pkg::rr_slot_t s;
        s.pc         = $urandom();
        s.inst       = $urandom();
        s.imm        = $urandom();
        s.rj         = `RR_AW'($urandom_range(0, 9));
        s.rk         = `RR_AW'($urandom_range(0, 9));
        s.rd         = `RR_AW'($urandom_range(0, 9));
        s.is_alu     = 1'($urandom_range(0, 1));
        s.is_load    = ($urandom_range(0, 3) == 0);
        s.is_syscall = 1'b0;
        s.is_break   = 1'b0;
        s.is_priv    = 1'b0;
        return s;
    endfunction

    function automatic rr_pkg::rr_bundle_t random_bundle();
        rr_pkg::rr_bundle_t b;
        b.slot0       = random_slot();
        b.slot1       = random_slot();
        b.pc_next     = $urandom();
        b.pc_taken    = 1'($urandom_range(0, 1));
        b.branch_flag = 1'($urandom_range(0, 1));
        b.excp_flag   = 1'($urandom_range(0, 1));
        b.exception   = `RR_EXCW'($urandom());
        b.badv        = $urandom();
        return b;
    endfunction

    function automatic rr_pkg::rr_wb_port_t random_wb();
        rr_pkg::rr_wb_port_t p;
        p.we   = 1'($urandom_range(0, 1));
        p.addr = `RR_AW'($urandom_range(0, 9));
        p.data = $urandom();
        return p;
    endfunction

    task automatic drive_lanes(input logic [3:0] flags);
        fwd_j0 = '{flag: flags[0], data: $urandom()};
        fwd_k0 = '{flag: flags[1], data: $urandom()};
        fwd_j1 = '{flag: flags[2], data: $urandom()};
        fwd_k1 = '{flag: flags[3], data: $urandom()};
    endtask

    // offer a bundle until the stage accepts it
    task automatic transfer_bundle(input rr_pkg::rr_bundle_t b);
        int waited;
        reg_bundle    = b;
        reg_readygo   = 1'b1;
        ex_allowin    = 1'b1;
        forward_stall = 1'b0;
        #1;
        for (waited = 0; !reg_allowin; waited++) begin
            if (waited == 20) begin
                $display("timed out waiting for reg_allowin at %0t", $time);
                $display("CHECKS FAILED");
                $fatal(1);
            end
            @(posedge clk);
            #6;
        end
        @(posedge clk);
        #5;
        reg_readygo = 1'b0;
    endtask

    initial begin
        rr_pkg::rr_bundle_t b;
        aresetn       = 1'b0;
        reg_bundle    = '0;
        reg_readygo   = 1'b0;
        wb0           = '0;
        wb1           = '0;
        wb2           = '0;
        fwd_j0        = '0;
        fwd_k0        = '0;
        fwd_j1        = '0;
        fwd_k1        = '0;
        ex_allowin    = 1'b0;
        forward_stall = 1'b0;
        stall_d       = 1'b0;
        flush         = 1'b0;
        flush_priv    = 1'b0;
        void'($urandom(32'h885a6462));
        repeat (5) @(posedge clk);
        #5;
        aresetn = 1'b1;

        // three ports hit r5 together, then all three hit r0
        wb0 = '{we: 1'b1, addr: `RR_AW'd5, data: 32'h0000_1111};
        wb1 = '{we: 1'b1, addr: `RR_AW'd5, data: 32'h0000_2222};
        wb2 = '{we: 1'b1, addr: `RR_AW'd5, data: 32'h0000_3333};
        b = random_bundle();
        b.slot0.is_load = 1'b0;
        b.slot0.rj = `RR_AW'd5;
        b.slot0.rk = `RR_AW'd0;
        b.slot1.rj = `RR_AW'd5;
        b.slot1.rk = `RR_AW'd0;
        transfer_bundle(b);
        wb0.addr = '0;
        wb1.addr = '0;
        wb2.addr = '0;
        transfer_bundle(b);
        wb0 = '0;
        wb1 = '0;
        wb2 = '0;
        transfer_bundle(b);

        // random writes and bundles, with the odd blocked cycle
        repeat (60) begin
            wb0 = random_wb();
            wb1 = random_wb();
            wb2 = random_wb();
            transfer_bundle(random_bundle());
            if ($urandom_range(0, 2) == 0) begin
                ex_allowin    = 1'b0;
                forward_stall = 1'($urandom_range(0, 1));
                step_cycle();
            end
        end
        wb0 = '0;
        wb1 = '0;
        wb2 = '0;

        // load in slot0, then a consumer of its rd
        b = random_bundle();
        b.slot0.is_load = 1'b1;
        b.slot0.rd = `RR_AW'd9;
        transfer_bundle(b);
        b = random_bundle();
        b.slot0.is_load = 1'b0;
        b.slot0.rj = `RR_AW'd1;
        b.slot0.rk = `RR_AW'd2;
        b.slot1.rj = `RR_AW'd3;
        b.slot1.rk = `RR_AW'd9;
        transfer_bundle(b);

        // flush held off by stall_d, then taken; then flush_priv
        transfer_bundle(random_bundle());
        ex_allowin = 1'b0;
        flush      = 1'b1;
        stall_d    = 1'b1;
        step_cycle();
        stall_d = 1'b0;
        step_cycle();
        flush = 1'b0;
        transfer_bundle(random_bundle());
        ex_allowin = 1'b0;
        flush_priv = 1'b1;
        stall_d    = 1'b1;
        step_cycle();
        flush_priv = 1'b0;
        stall_d    = 1'b0;

        // late forwards while execute is blocked
        transfer_bundle(random_bundle());
        ex_allowin = 1'b0;
        stall_d    = 1'b1;
        for (int c = 0; c < 6; c++) begin
            drive_lanes(c == 1 ? 4'b1001 : (c == 3 ? 4'b0010 : 4'b0000));
            step_cycle();
        end
        stall_d = 1'b0;
        for (int c = 0; c < 4; c++) begin
            drive_lanes(c == 2 ? 4'b0100 : 4'b0000);
            step_cycle();
        end
        drive_lanes(4'b0000);
        transfer_bundle(random_bundle());
        step_cycle();
        step_cycle();

        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* rr_stage.f */
+incdir+include
src/rr_pkg.sv
src/reg_file.sv
src/rr_hazard_ctrl.sv
src/rr_stage_reg.sv
src/rr_stage_top.sv
bench/rr_stage_tb.sv

/* run.sh */
#!/bin/sh
# build and run the register-read stage testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f rr_stage.f --top-module rr_stage_tb -o rr_stage_sim

./obj_dir/rr_stage_sim
